/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mul_fu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* mul_cdb_arbiter.sv */
`default_nettype none

module mul_cdb_arbiter #(
    parameter int NUM_MUL   = 2,
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [NUM_MUL-1:0]           done,
    input  logic [31:0]                  result [NUM_MUL],
    input  logic [$clog2(ROB_DEPTH)-1:0] tag    [NUM_MUL],
    output logic [NUM_MUL-1:0]           ack,
    output rv32_mul_pkg::cdb_t           cdb
);
    localparam int PTR_W = (NUM_MUL > 1) ? $clog2(NUM_MUL) : 1;

    // Unit with the highest priority in the current cycle
    logic [PTR_W-1:0] ptr;

    logic [NUM_MUL-1:0] grant;
    logic               any_done;
    int                 win;

    // Scan from the pointer around the ring and stop at the first done unit
    always_comb begin
        int idx;
        grant    = '0;
        any_done = 1'b0;
        win      = 0;
        for (int k = 0; k < NUM_MUL; k++) begin
            idx = (int'(ptr) + k) % NUM_MUL;
            if (!any_done && done[idx]) begin
                any_done   = 1'b1;
                grant[idx] = 1'b1;
                win        = idx;
            end
        end
    end

    // The winner sees its ack in the same cycle its result is registered
    // Its done drops on the following edge, so it cannot win twice
    assign ack = grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr       <= '0;
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= any_done;
            // Step past the winner so the others get their turn first
            if (any_done) begin
                ptr <= PTR_W'((win + 1) % NUM_MUL);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (any_done) begin
            cdb.rob_idx  <= tag[win];
            cdb.rd_value <= result[win];
        end
    end

endmodule

`default_nettype wire

/* mul_dispatch.sv */
`default_nettype none

module mul_dispatch #(
    parameter int NUM_MUL = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  rv32_mul_pkg::mul_issue_t   issue,
    input  logic [NUM_MUL-1:0]         busy,
    output logic                       fu_ready,
    output rv32_mul_pkg::mul_req_t     req [NUM_MUL]
);
    import rv32_mul_pkg::*;

    // Start strobes toward each unit, cleared by reset
    logic [NUM_MUL-1:0] start_q;

    // Operation payload held per unit, only meaningful while its start is high
    mul_op_t              op_q  [NUM_MUL];
    logic [31:0]          a_q   [NUM_MUL];
    logic [31:0]          b_q   [NUM_MUL];
    logic [ROB_IDX_W-1:0] tag_q [NUM_MUL];

    logic [NUM_MUL-1:0] free;
    logic [NUM_MUL-1:0] grant;

    // A unit issued to in the last cycle has its start pending but busy not yet up
    // Counting the pending start as taken keeps the same unit from being picked twice
    assign free = ~(busy | start_q);

    // Ready as long as any unit can take an operation in this cycle
    assign fu_ready = |free;

    // Priority pick of the lowest-numbered free unit
    always_comb begin
        logic found;
        found = 1'b0;
        grant = '0;
        for (int i = 0; i < NUM_MUL; i++) begin
            if (!found && free[i]) begin
                grant[i] = 1'b1;
                found    = 1'b1;
            end
        end
    end

    // The start bit is a single-cycle strobe into the granted unit
    always_ff @(posedge clk) begin
        if (rst) begin
            start_q <= '0;
        end else begin
            start_q <= issue.start ? grant : '0;
        end
    end

    // Capture the operands into the granted slot only
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_MUL; i++) begin
            if (issue.start && grant[i]) begin
                op_q[i]  <= issue.op;
                a_q[i]   <= issue.rs1_v;
                b_q[i]   <= issue.rs2_v;
                tag_q[i] <= issue.rob_idx;
            end
        end
    end

    // Assemble the request words seen by the multipliers
    always_comb begin
        for (int i = 0; i < NUM_MUL; i++) begin
            req[i].start   = start_q[i];
            req[i].op      = op_q[i];
            req[i].a       = a_q[i];
            req[i].b       = b_q[i];
            req[i].rob_idx = tag_q[i];
        end
    end

endmodule

`default_nettype wire

/* mul_fu_properties.sv */
`default_nettype none

module mul_fu_properties #(
    parameter int NUM_MUL = 2
) (
    input logic                     clk,
    input logic                     rst,
    input rv32_mul_pkg::mul_issue_t issue,
    input logic                     fu_ready,
    input rv32_mul_pkg::cdb_t       cdb,
    input logic [NUM_MUL-1:0]       ack
);
    timeunit 1ns;
    timeprecision 1ps;

    // The issue logic may only strobe while some unit is free
    a_issue_when_ready: assert property (@(posedge clk) disable iff (rst)
        issue.start |-> fu_ready)
        else $error("Issue strobe arrived while fu_ready was low");

    // A result is broadcast once, so two valid cycles in a row carry different tags
    a_cdb_once: assert property (@(posedge clk) disable iff (rst)
        (cdb.valid && $past(cdb.valid)) |-> (cdb.rob_idx != $past(cdb.rob_idx)))
        else $error("CDB held the same tag valid for two cycles");

    // The arbiter grants at most one unit per cycle
    a_ack_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack))
        else $error("More than one ack in the same cycle");

endmodule

bind mul_fu_top mul_fu_properties #(
    .NUM_MUL (NUM_MUL)
) props (
    .clk      (clk),
    .rst      (rst),
    .issue    (issue),
    .fu_ready (fu_ready),
    .cdb      (cdb),
    .ack      (ack)
);

`default_nettype wire

/* mul_fu_top.sv */
`default_nettype none

module mul_fu_top #(
    parameter int NUM_MUL   = 2,
    parameter int ROB_DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  rv32_mul_pkg::mul_issue_t issue,
    output logic                     fu_ready,
    output rv32_mul_pkg::cdb_t       cdb
);
    import rv32_mul_pkg::*;

    localparam int TAG_W = $clog2(ROB_DEPTH);

    // Dispatcher to multipliers
    mul_req_t           req [NUM_MUL];
    logic [NUM_MUL-1:0] busy;

    // Multipliers to arbiter
    logic [NUM_MUL-1:0] done;
    logic [NUM_MUL-1:0] ack;
    logic [31:0]        result [NUM_MUL];
    logic [TAG_W-1:0]   tag    [NUM_MUL];

    mul_dispatch #(
        .NUM_MUL (NUM_MUL)
    ) u_dispatch (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .busy     (busy),
        .fu_ready (fu_ready),
        .req      (req)
    );

    // One identical sequential multiplier per slot
    for (genvar i = 0; i < NUM_MUL; i++) begin : g_mul
        shift_add_multiplier #(
            .ROB_DEPTH (ROB_DEPTH)
        ) u_mul (
            .clk    (clk),
            .rst    (rst),
            .req    (req[i]),
            .ack    (ack[i]),
            .busy   (busy[i]),
            .done   (done[i]),
            .result (result[i]),
            .tag    (tag[i])
        );
    end

    mul_cdb_arbiter #(
        .NUM_MUL   (NUM_MUL),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_arbiter (
        .clk    (clk),
        .rst    (rst),
        .done   (done),
        .result (result),
        .tag    (tag),
        .ack    (ack),
        .cdb    (cdb)
    );

endmodule

`default_nettype wire

/* mul_tests.txt */
# Columns in hex: op (0 MUL, 1 MULH, 2 MULHSU, 3 MULHU), operand a, operand b, tag, expected
# Expected is the low word for MUL and the high word of the 64-bit product otherwise
0 00000007 00000006 0 0000002a
0 fffffffd 00000005 1 fffffff1
0 80000000 ffffffff 2 80000000
0 00000000 deadbeef 3 00000000
0 0000ffff 0000ffff 4 fffe0001
1 80000000 80000000 5 40000000
1 ffffffff ffffffff 6 00000000
1 fffffffe 00000003 7 ffffffff
1 7fffffff 7fffffff 0 3fffffff
2 ffffffff ffffffff 1 ffffffff
2 7fffffff ffffffff 2 7ffffffe
2 80000000 80000000 3 c0000000
3 ffffffff ffffffff 4 fffffffe
3 80000000 00000002 5 00000001

/* rv32_mul_pkg.sv */
`default_nettype none

package rv32_mul_pkg;

    // Width of the reorder-buffer tag carried with every multiply
    // The top level derives its own tag width from ROB_DEPTH and matches this by default
    localparam int ROB_IDX_W = 3;

    // The four RV32M multiply flavours
    // MUL returns the low word, the others return the high word of the 64-bit product
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_op_t;

    // One operation handed over by the issue logic
    // The start bit is a single-cycle strobe and the rest is payload
    typedef struct packed {
        logic                 start;
        mul_op_t              op;
        logic [31:0]          rs1_v;
        logic [31:0]          rs2_v;
        logic [ROB_IDX_W-1:0] rob_idx;
    } mul_issue_t;

    // Request from the dispatcher to a single multiplier
    // Same content as the issue word, but registered and steered to one unit
    typedef struct packed {
        logic                 start;
        mul_op_t              op;
        logic [31:0]          a;
        logic [31:0]          b;
        logic [ROB_IDX_W-1:0] rob_idx;
    } mul_req_t;

    // Result broadcast on the common data bus
    // Valid is high for one cycle per finished multiply
    typedef struct packed {
        logic                 valid;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [31:0]          rd_value;
    } cdb_t;

endpackage

`default_nettype wire

/* shift_add_multiplier.sv */
`default_nettype none

module shift_add_multiplier #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  rv32_mul_pkg::mul_req_t       req,
    input  logic                         ack,
    output logic                         busy,
    output logic                         done,
    output logic [31:0]                  result,
    output logic [$clog2(ROB_DEPTH)-1:0] tag
);
    import rv32_mul_pkg::*;

    // Control state
    logic       running;
    logic [4:0] count;

    // Datapath registers loaded on start
    logic [31:0] mcand;
    logic [63:0] acc;
    logic        negate;
    logic        want_low;

    // Operand conditioning on the incoming request
    logic        a_signed;
    logic        b_signed;
    logic        a_neg;
    logic        b_neg;
    logic [31:0] a_mag;
    logic [31:0] b_mag;

    // One add-and-shift step and the final sign fix-up
    logic [32:0] partial;
    logic [63:0] acc_next;
    logic [63:0] product;
    logic        last_iter;
    logic        load;

    // Busy covers the iterations and the wait for the arbiter
    assign busy = running | done;
    assign load = req.start && !busy;

    // MUL is taken as signed by signed, its low word is the same either way
    always_comb begin
        a_signed = (req.op != MULHU);
        b_signed = (req.op == MUL) || (req.op == MULH);
        a_neg    = a_signed && req.a[31];
        b_neg    = b_signed && req.b[31];
        // The magnitude of the most negative value still fits as unsigned
        a_mag    = a_neg ? (~req.a + 32'd1) : req.a;
        b_mag    = b_neg ? (~req.b + 32'd1) : req.b;
    end

    // The multiplier sits in the low half of acc and is shifted out bit by bit
    // The multiplicand is added into the high half when the current bit is set
    assign partial   = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mcand} : 33'd0);
    assign acc_next  = {partial, acc[31:1]};
    assign product   = negate ? (~acc_next + 64'd1) : acc_next;
    assign last_iter = (count == 5'd31);

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            if (load) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 5'd1;
                // Sign fix-up happens on the edge of the last iteration
                if (last_iter) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end else if (done && ack) begin
                done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            acc      <= {32'd0, b_mag};
            mcand    <= a_mag;
            negate   <= a_neg ^ b_neg;
            want_low <= (req.op == MUL);
            tag      <= req.rob_idx;
        end else if (running) begin
            acc <= acc_next;
            if (last_iter) begin
                result <= want_low ? product[31:0] : product[63:32];
            end
        end
    end

endmodule

`default_nettype wire

/* tb.f */
rv32_mul_pkg.sv
mul_dispatch.sv
shift_add_multiplier.sv
mul_cdb_arbiter.sv
mul_fu_top.sv
mul_fu_properties.sv
tb_mul_fu.sv

/* tb_mul_fu.sv */
`default_nettype none

module tb_mul_fu;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32_mul_pkg::*;

    localparam int NUM_MUL   = 2;
    localparam int ROB_DEPTH = 8;
    localparam int LATENCY   = 35;
    localparam int NUM_RAND  = 40;

    // One test vector as read from the file or built at random
    typedef struct packed {
        mul_op_t     op;
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  tag;
        logic [31:0] expected;
    } vec_t;

    // Declared with a value so that the first falling edge comes at 8 ns
    logic       clk = 1'b0;
    logic       rst;
    mul_issue_t issue;
    logic       fu_ready;
    cdb_t       cdb;

    // Scoreboard indexed by tag
    logic [31:0] exp_value   [ROB_DEPTH];
    int          issue_cycle [ROB_DEPTH];
    string       test_name   [ROB_DEPTH];
    logic        pending     [ROB_DEPTH];
    int          num_pending;
    // Directed vectors run alone and must hit the latency exactly
    bit          exact_latency;

    vec_t dir_q [$];
    int   cycle = 0;
    int   cycle_limit;

    mul_fu_top #(
        .NUM_MUL   (NUM_MUL),
        .ROB_DEPTH (ROB_DEPTH)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .fu_ready (fu_ready),
        .cdb      (cdb)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // Rising edges since time zero, read by the main flow on falling edges
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            fail_run($sformatf("Run timed out after %0d cycles", cycle_limit));
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // Full 64-bit product with each operand extended as its op demands
    function automatic logic [31:0] model_mul(input mul_op_t op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [63:0] wa;
        logic [63:0] wb;
        logic [63:0] prod;
        wa   = (op == MULHU) ? {32'd0, a} : {{32{a[31]}}, a};
        wb   = (op == MUL || op == MULH) ? {{32{b[31]}}, b} : {32'd0, b};
        prod = wa * wb;
        return (op == MUL) ? prod[31:0] : prod[63:32];
    endfunction

    // Mostly random words, with the corner values mixed in often
    function automatic logic [31:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            3:       return 32'h7fff_ffff;
            default: return $urandom();
        endcase
    endfunction

    // Match a CDB broadcast against the scoreboard
    task automatic collect_result();
        int          lat;
        logic [2:0]  t;
        t = cdb.rob_idx;
        if (cdb.valid) begin
            if (!pending[t]) begin
                fail_run($sformatf("CDB returned tag %0d while it was not outstanding", t));
            end
            lat = cycle - issue_cycle[t];
            check_value(test_name[t], exp_value[t], cdb.rd_value);
            if (exact_latency) begin
                check_value({test_name[t], " latency"}, LATENCY, lat);
            end else if (lat < LATENCY) begin
                fail_run($sformatf("Result of %s came back after only %0d cycles",
                                   test_name[t], lat));
            end
            pending[t]  = 1'b0;
            num_pending = num_pending - 1;
        end
    endtask

    // Advance to the next falling edge, end any strobe and look at the CDB
    task automatic next_cycle();
        @(negedge clk);
        issue.start = 1'b0;
        collect_result();
    endtask

    // Issue on the first cycle where a unit is free and the tag is unused
    task automatic send(input string name, input vec_t v);
        next_cycle();
        while (!fu_ready || pending[v.tag]) begin
            next_cycle();
        end
        issue.start        = 1'b1;
        issue.op           = v.op;
        issue.rs1_v        = v.a;
        issue.rs2_v        = v.b;
        issue.rob_idx      = v.tag;
        pending[v.tag]     = 1'b1;
        exp_value[v.tag]   = v.expected;
        issue_cycle[v.tag] = cycle;
        test_name[v.tag]   = name;
        num_pending        = num_pending + 1;
    endtask

    task automatic drain();
        while (num_pending > 0) begin
            next_cycle();
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_tag;
        logic [31:0] f_exp;
        vec_t        v;
        logic [2:0]  next_tag;

        rst           = 1'b1;
        issue         = '0;
        num_pending   = 0;
        exact_latency = 1'b1;
        next_tag      = 3'd0;
        void'($urandom(32'haef75ce9));
        foreach (pending[i]) begin
            pending[i] = 1'b0;
        end

        // Comment and blank lines fail the scan and are skipped
        fd = $fopen("mul_tests.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open mul_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            n    = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_tag, f_exp);
            if (n == 5) begin
                dir_q.push_back({mul_op_t'(f_op[1:0]), f_a, f_b, f_tag[2:0], f_exp});
            end
        end
        $fclose(fd);
        cycle_limit = (dir_q.size() + NUM_RAND + 4) * 40;

        repeat (3) @(negedge clk);
        rst = 1'b0;

        next_cycle();
        check_value("reset_fu_ready", 32'd1, {31'd0, fu_ready});
        check_value("reset_cdb_valid", 32'd0, {31'd0, cdb.valid});

        // Directed vectors one at a time, so no result competes for the CDB
        foreach (dir_q[i]) begin
            send($sformatf("directed_%0d", i), dir_q[i]);
            drain();
        end

        // Random vectors back to back, the first NUM_MUL of them fill every unit
        exact_latency = 1'b0;
        for (int i = 0; i < NUM_RAND; i++) begin
            v.op       = mul_op_t'(2'($urandom_range(0, 3)));
            v.a        = pick_operand();
            v.b        = pick_operand();
            v.tag      = next_tag;
            v.expected = model_mul(v.op, v.a, v.b);
            send($sformatf("random_%0d", i), v);
            next_tag = next_tag + 3'd1;
            if (i == NUM_MUL - 1) begin
                next_cycle();
                while (!cdb.valid) begin
                    check_value("fu_ready_while_full", 32'd0, {31'd0, fu_ready});
                    next_cycle();
                end
            end
        end

        // Every result is due one latency after its issue
        // The second latency leaves room for a duplicate broadcast to show up
        repeat (2 * LATENCY) next_cycle();
        if (num_pending != 0) begin
            fail_run("Tags were still outstanding at the end of the run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
